// ==== source/rx_bert_pkg.sv ====
// Receive BERT shared definitions
// Widths, rate-mode and pattern encodings, bits-per-clock decode

package rx_bert_pkg;

  localparam int ERR_CNT_W = 16;  // Error counter width per checker
  localparam int BIT_CNT_W = 32;  // Shared bit counter width
  localparam int LANE_BITS = 8;   // Bit slots per lane in one FIFO word
  localparam int SEED_BITS = 16;  // Bits shifted in before comparing

  typedef enum logic [1:0] {
    FIFO_1X = 2'b00,  // Full rate
    FIFO_2X = 2'b01,  // Half rate
    FIFO_4X = 2'b10   // Quarter rate
  } fifo_mode_e;

  typedef enum logic {
    PTRN_PRBS7  = 1'b0,  // x^7+x^6+1
    PTRN_PRBS15 = 1'b1   // x^15+x^14+1
  } ptrn_e;

  typedef enum logic [1:0] {
    NBIT1 = 2'b00,  // 1 bit per clock
    NBIT2 = 2'b01,  // 2 bits per clock
    NBIT4 = 2'b10,  // 4 bits per clock
    NBIT8 = 2'b11   // 8 bits per clock
  } nbits_e;

  // Valid bits per clock from FIFO rate and data rate
  function automatic nbits_e nbits_from_mode(fifo_mode_e mode, logic sdr);
    case (mode)
      FIFO_1X: return sdr ? NBIT1 : NBIT2;
      FIFO_2X: return sdr ? NBIT2 : NBIT4;
      FIFO_4X: return sdr ? NBIT4 : NBIT8;
      default: return sdr ? NBIT1 : NBIT2;  // Unsupported, treat as full rate
    endcase
  endfunction

endpackage

// ==== source/bert_chk_if.sv ====
// Checker control interface
// Carries clear, seed and compare strobes plus pattern select to one checker

`timescale 1ns/1ns

interface bert_chk_if;

  logic                clr;   // Clear pulse for count and pattern register
  logic                seed;  // Shift received bits into pattern register
  logic                cmp;   // Compare received bits against prediction
  rx_bert_pkg::ptrn_e  ptrn;  // Latched pattern select

  // State machine side
  modport fsm (
    output clr,
    output seed,
    output cmp,
    output ptrn
  );

  // Pattern checker side
  modport chk (
    input clr,
    input seed,
    input cmp,
    input ptrn
  );

endinterface

// ==== source/rx_lane_select.sv ====
// Receive lane selector
// Splits the FIFO word into lane bytes and registers one masked lane per checker

`timescale 1ns/1ns

module rx_lane_select #(
  parameter int NUM_LANES = 8,
  parameter int NUM_CHK   = 2
) (
  input  logic                                           clk,
  input  logic                                           rstn,
  input  logic [rx_bert_pkg::LANE_BITS*NUM_LANES-1:0]    rx_data_i,    // Word from RX FIFO
  input  rx_bert_pkg::nbits_e                            nbits_i,      // Valid bits per clock
  input  logic [NUM_CHK-1:0][5:0]                        lane_sel_i,   // Lane per checker
  output logic [NUM_CHK-1:0][rx_bert_pkg::LANE_BITS-1:0] lane_byte_o   // Registered lane bytes
);

  logic [NUM_LANES-1:0][rx_bert_pkg::LANE_BITS-1:0] lane_bytes;  // Word regrouped per lane
  logic [NUM_CHK-1:0][rx_bert_pkg::LANE_BITS-1:0]   chk_bytes;   // Selected and masked
  logic [rx_bert_pkg::LANE_BITS-1:0]                valid_mask;  // Slots in use this clock

  //------------------------------------------------------------
  // Lane map, slot k of lane i sits at bit k*NUM_LANES+i
  //------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      for (int k = 0; k < rx_bert_pkg::LANE_BITS; k++)
      begin
        lane_bytes[i][k] = rx_data_i[k*NUM_LANES+i];  // Slot 0 is oldest
      end
    end
  end

  always_comb
  begin
    case (nbits_i)
      rx_bert_pkg::NBIT1: valid_mask = 8'h01;
      rx_bert_pkg::NBIT2: valid_mask = 8'h03;
      rx_bert_pkg::NBIT4: valid_mask = 8'h0f;
      default:            valid_mask = 8'hff;
    endcase
  end

  //------------------------------------------------------------
  // Per-checker lane mux
  //------------------------------------------------------------
  always_comb
  begin
    for (int c = 0; c < NUM_CHK; c++)
    begin
      if (lane_sel_i[c] < NUM_LANES)
        chk_bytes[c] = lane_bytes[lane_sel_i[c]] & valid_mask;
      else
        chk_bytes[c] = '0;  // Out of range lane reads as zero
    end
  end

  // Register before the checkers to ease timing
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      lane_byte_o <= '0;
    else
      lane_byte_o <= chk_bytes;
  end

endmodule

// ==== source/bert_chk_fsm.sv ====
// Checker control FSM
// Steps one checker through idle, seed and run and drives its strobes

`timescale 1ns/1ns

module bert_chk_fsm (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rst_pulse_i,    // Return to idle, clear counts
  input  logic                start_pulse_i,  // Begin seeding
  input  rx_bert_pkg::ptrn_e  ptrn_sel_i,     // Pattern for this run
  input  rx_bert_pkg::nbits_e nbits_i,        // Valid bits per clock
  output logic                running_o,      // High through seed and run
  bert_chk_if.fsm             chk
);

  localparam int CNT_W = $clog2(rx_bert_pkg::SEED_BITS + 1);

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_SEED = 2'b01,
    ST_RUN  = 2'b10
  } state_e;

  state_e              state_q;   // Current state
  logic [CNT_W-1:0]    seed_cnt;  // Seed cycles still to go
  rx_bert_pkg::ptrn_e  ptrn_q;    // Pattern latched at start
  logic [CNT_W-1:0]    seed_len;  // Seed cycles for current rate

  assign seed_len = CNT_W'(rx_bert_pkg::SEED_BITS >> nbits_i);  // SEED_BITS / nbits

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q  <= ST_IDLE;
      seed_cnt <= '0;
      ptrn_q   <= rx_bert_pkg::PTRN_PRBS7;
    end
    else if (rst_pulse_i)  // Reset wins over start
    begin
      state_q  <= ST_IDLE;
      seed_cnt <= '0;
    end
    else if (start_pulse_i)  // Also restarts a running checker
    begin
      state_q  <= ST_SEED;
      seed_cnt <= seed_len;
      ptrn_q   <= ptrn_sel_i;
    end
    else if (state_q == ST_SEED)
    begin
      if (seed_cnt == CNT_W'(1))
        state_q <= ST_RUN;  // Last seed cycle
      seed_cnt <= seed_cnt - CNT_W'(1);
    end
  end

  // Strobes decoded from state
  assign running_o = (state_q != ST_IDLE);
  assign chk.seed  = (state_q == ST_SEED);
  assign chk.cmp   = (state_q == ST_RUN);
  assign chk.clr   = rst_pulse_i | start_pulse_i;  // Same cycle as the pulse
  assign chk.ptrn  = ptrn_q;

endmodule

// ==== source/prbs_checker.sv ====
// PRBS pattern checker
// Seeds a 15-bit LFSR from received bits, then counts mismatches with saturation

`timescale 1ns/1ns

module prbs_checker (
  input  logic                                clk,
  input  logic                                rstn,
  input  rx_bert_pkg::nbits_e                 nbits_i,      // Valid bits per clock
  input  logic [rx_bert_pkg::LANE_BITS-1:0]   lane_byte_i,  // Slot 0 oldest
  bert_chk_if.chk                             chk,
  output logic [rx_bert_pkg::ERR_CNT_W-1:0]   err_cnt_o     // Saturating error count
);

  localparam int SUM_W = $clog2(rx_bert_pkg::LANE_BITS + 1);

  logic [14:0]                        ptrn_q;    // Pattern register
  logic [14:0]                        ptrn_nxt;  // After this clock's bits
  logic                               pred;      // Predicted bit for current slot
  logic                               prbs15;    // Long pattern selected
  logic [3:0]                         nbit_cnt;  // Bits to process, 1 to 8
  logic [SUM_W-1:0]                   err_sum;   // Mismatches this clock
  logic [rx_bert_pkg::ERR_CNT_W:0]    err_add;   // Count plus carry

  assign prbs15   = (chk.ptrn == rx_bert_pkg::PTRN_PRBS15);
  assign nbit_cnt = 4'd1 << nbits_i;

  //------------------------------------------------------------
  // Bit-serial LFSR walk over the valid slots
  //------------------------------------------------------------
  always_comb
  begin
    ptrn_nxt = chk.clr ? 15'd0 : ptrn_q;  // Start clean on clear
    err_sum  = '0;
    pred     = 1'b0;
    for (int b = 0; b < rx_bert_pkg::LANE_BITS; b++)
    begin
      if (b < nbit_cnt)
      begin
        // Fibonacci taps, newest bit enters at bit 0
        pred = prbs15 ? (ptrn_nxt[14] ^ ptrn_nxt[13]) : (ptrn_nxt[6] ^ ptrn_nxt[5]);
        if (chk.seed)
        begin
          ptrn_nxt = {ptrn_nxt[13:0], lane_byte_i[b]};  // Load from line
        end
        else if (chk.cmp)
        begin
          err_sum  = err_sum + SUM_W'(pred ^ lane_byte_i[b]);
          ptrn_nxt = {ptrn_nxt[13:0], pred};  // Free-run on own feedback
        end
      end
    end
    if (!prbs15)
      ptrn_nxt[14:7] = '0;  // PRBS7 keeps low 7 bits only
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      ptrn_q <= '0;
    else
      ptrn_q <= ptrn_nxt;
  end

  //------------------------------------------------------------
  // Error counter
  //------------------------------------------------------------
  assign err_add = {1'b0, err_cnt_o} + (rx_bert_pkg::ERR_CNT_W + 1)'(err_sum);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      err_cnt_o <= '0;
    else if (chk.clr)
      err_cnt_o <= '0;
    else if (chk.cmp)
    begin
      if (err_add[rx_bert_pkg::ERR_CNT_W])
        err_cnt_o <= '1;  // Saturate
      else
        err_cnt_o <= err_add[rx_bert_pkg::ERR_CNT_W-1:0];
    end
  end

endmodule

// ==== source/rx_bit_counter.sv ====
// Received bit counter
// Accumulates bits per clock while any checker runs

`timescale 1ns/1ns

module rx_bit_counter #(
  parameter int NUM_CHK = 2
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [NUM_CHK-1:0]                rst_pulse_i,  // Any set bit clears
  input  logic [NUM_CHK-1:0]                running_i,    // Checker running flags
  input  rx_bert_pkg::nbits_e               nbits_i,      // Valid bits per clock
  output logic [rx_bert_pkg::BIT_CNT_W-1:0] bit_cnt_o     // Total bits received
);

  logic [rx_bert_pkg::BIT_CNT_W-1:0] bit_inc;  // 1, 2, 4 or 8

  assign bit_inc = rx_bert_pkg::BIT_CNT_W'(1) << nbits_i;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      bit_cnt_o <= '0;
    else if (|rst_pulse_i)
      bit_cnt_o <= '0;
    else if (|running_i)
      bit_cnt_o <= bit_cnt_o + bit_inc;  // Wraps at full scale
  end

endmodule

// ==== source/rx_bert_top.sv ====
// Receive BERT top level
// Lane selection, NUM_CHK PRBS checkers and the shared bit counter

`timescale 1ns/1ns

module rx_bert_top #(
  parameter int NUM_LANES = 8,
  parameter int NUM_CHK   = 2
) (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  logic [rx_bert_pkg::LANE_BITS*NUM_LANES-1:0]   rx_data_i,      // RX FIFO word
  input  rx_bert_pkg::fifo_mode_e                       fifo_mode_i,    // FIFO rate
  input  logic                                          sdr_mode_i,     // Single data rate
  input  logic [NUM_CHK-1:0]                            rst_pulse_i,    // Per checker
  input  logic [NUM_CHK-1:0]                            start_pulse_i,  // Per checker
  input  logic [6*NUM_CHK-1:0]                          lane_sel_i,     // 6 bits per checker
  input  logic [NUM_CHK-1:0]                            ptrn_sel_i,     // 1 = PRBS15
  output logic [rx_bert_pkg::BIT_CNT_W-1:0]             bit_cnt_o,      // Bits received
  output logic [rx_bert_pkg::ERR_CNT_W*NUM_CHK-1:0]     err_cnt_o,      // Per checker
  output logic [NUM_CHK-1:0]                            running_o       // Per checker
);

  rx_bert_pkg::nbits_e                            nbits;      // Decoded once for all blocks
  logic [NUM_CHK-1:0][5:0]                        lane_sel;   // Unflattened selects
  logic [NUM_CHK-1:0][rx_bert_pkg::LANE_BITS-1:0] lane_byte;  // Registered lane data

  assign nbits    = rx_bert_pkg::nbits_from_mode(fifo_mode_i, sdr_mode_i);
  assign lane_sel = lane_sel_i;

  rx_lane_select #(
    .NUM_LANES (NUM_LANES),
    .NUM_CHK   (NUM_CHK)
  ) u_lane_select (
    .clk         (clk),
    .rstn        (rstn),
    .rx_data_i   (rx_data_i),
    .nbits_i     (nbits),
    .lane_sel_i  (lane_sel),
    .lane_byte_o (lane_byte)
  );

  //------------------------------------------------------------
  // Checkers
  //------------------------------------------------------------
  for (genvar c = 0; c < NUM_CHK; c++)
  begin : g_chk
    bert_chk_if chk_if ();

    bert_chk_fsm u_fsm (
      .clk           (clk),
      .rstn          (rstn),
      .rst_pulse_i   (rst_pulse_i[c]),
      .start_pulse_i (start_pulse_i[c]),
      .ptrn_sel_i    (rx_bert_pkg::ptrn_e'(ptrn_sel_i[c])),
      .nbits_i       (nbits),
      .running_o     (running_o[c]),
      .chk           (chk_if.fsm)
    );

    prbs_checker u_checker (
      .clk         (clk),
      .rstn        (rstn),
      .nbits_i     (nbits),
      .lane_byte_i (lane_byte[c]),
      .chk         (chk_if.chk),
      .err_cnt_o   (err_cnt_o[c*rx_bert_pkg::ERR_CNT_W +: rx_bert_pkg::ERR_CNT_W])
    );
  end

  rx_bit_counter #(
    .NUM_CHK (NUM_CHK)
  ) u_bit_counter (
    .clk         (clk),
    .rstn        (rstn),
    .rst_pulse_i (rst_pulse_i),
    .running_i   (running_o),
    .nbits_i     (nbits),
    .bit_cnt_o   (bit_cnt_o)
  );

endmodule

// ==== tb/rx_bert_monitor.sv ====
// Receive BERT output monitor
// Compares DUT counts and running flags with expected values on each check strobe

`timescale 1ns/1ns

module rx_bert_monitor #(
  parameter int NUM_CHK = 2
) (
  input  logic                                      clk,
  input  logic                                      check_i,        // Compare this cycle
  input  logic [rx_bert_pkg::BIT_CNT_W-1:0]         exp_bit_cnt_i,  // Expected bit count
  input  logic [rx_bert_pkg::ERR_CNT_W*NUM_CHK-1:0] exp_err_cnt_i,  // Expected error counts
  input  logic [NUM_CHK-1:0]                        exp_running_i,  // Expected running flags
  input  logic [rx_bert_pkg::BIT_CNT_W-1:0]         bit_cnt_i,      // From DUT
  input  logic [rx_bert_pkg::ERR_CNT_W*NUM_CHK-1:0] err_cnt_i,      // From DUT
  input  logic [NUM_CHK-1:0]                        running_i,      // From DUT
  output int                                        check_cnt_o,    // Strobes seen
  output int                                        error_cnt_o     // Mismatches found
);

  localparam int EW = rx_bert_pkg::ERR_CNT_W;

  // Compare one field against its expected value
  task automatic compare_hex(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    if (exp_v !== got_v)
    begin
      $display("CHECK FAILED: %s expected %h got %h at %0t", name, exp_v, got_v, $time);
      error_cnt_o = error_cnt_o + 1;
    end
  endtask

  initial
  begin
    check_cnt_o = 0;
    error_cnt_o = 0;
  end

  //------------------------------------------------------------
  // Sample on the falling edge away from the driving edge
  //------------------------------------------------------------
  always @(negedge clk)
  begin
    if (check_i)
    begin
      check_cnt_o = check_cnt_o + 1;
      compare_hex("bit_cnt_o", exp_bit_cnt_i, bit_cnt_i);
      compare_hex("running_o", exp_running_i, running_i);
      for (int c = 0; c < NUM_CHK; c++)
      begin
        compare_hex($sformatf("err_cnt_o[%0d]", c), exp_err_cnt_i[c*EW +: EW],
                    err_cnt_i[c*EW +: EW]);
      end
    end
  end

endmodule

// ==== tb/tb_rx_bert.sv ====
// Receive BERT testbench
// PRBS streams on selected lanes, bit flips, table of rows applied in a loop

`timescale 1ns/1ns

module tb_rx_bert;

  localparam int NUM_LANES   = 8;
  localparam int NUM_CHK     = 2;
  localparam int WORD_W      = rx_bert_pkg::LANE_BITS * NUM_LANES;
  localparam int EW          = rx_bert_pkg::ERR_CNT_W;
  localparam int NUM_ROWS    = 6;
  localparam int NUM_CHECKS  = 1 + 2 * NUM_ROWS;  // After reset, then two per row
  localparam int MAX_FLIPS   = 4;
  localparam int MAX_BITS    = 512;  // Stream bits per checker and row
  localparam int RUN_TIMEOUT = 8;    // Cycles allowed for running to rise

  logic                              clk;
  logic                              rstn;
  logic [WORD_W-1:0]                 rx_data;
  rx_bert_pkg::fifo_mode_e           fifo_mode;
  logic                              sdr;
  logic [NUM_CHK-1:0]                rst_pulse;
  logic [NUM_CHK-1:0]                start_pulse;
  logic [6*NUM_CHK-1:0]              lane_sel;
  logic [NUM_CHK-1:0]                ptrn_sel;
  logic [rx_bert_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [EW*NUM_CHK-1:0]             err_cnt;
  logic [NUM_CHK-1:0]                running;

  logic                              check_stb;    // Strobe to monitor
  logic [rx_bert_pkg::BIT_CNT_W-1:0] exp_bit_cnt;
  logic [EW*NUM_CHK-1:0]             exp_err_cnt;
  logic [NUM_CHK-1:0]                exp_running;
  int                                check_cnt;
  int                                error_cnt;
  int                                timeouts;
  integer                            seed = 24;   // $random state

  // Stimulus table with one entry per row and checker
  rx_bert_pkg::fifo_mode_e row_mode [NUM_ROWS];
  logic                    row_sdr  [NUM_ROWS];
  int                      row_len  [NUM_ROWS];             // Stream cycles
  int                      row_lane [NUM_ROWS][NUM_CHK];
  logic                    row_ptrn [NUM_ROWS][NUM_CHK];    // 1 = PRBS15
  int                      row_nflip[NUM_ROWS][NUM_CHK];
  int                      row_flip [NUM_ROWS][NUM_CHK][MAX_FLIPS];

  // Current row streams
  logic clean_bits [NUM_CHK][MAX_BITS];  // Pure pattern
  logic line_bits  [NUM_CHK][MAX_BITS];  // What the checker receives
  int   cur_lane   [NUM_CHK];
  int   cur_nbits;

  rx_bert_top #(
    .NUM_LANES (NUM_LANES),
    .NUM_CHK   (NUM_CHK)
  ) dut_i (
    .clk           (clk),
    .rstn          (rstn),
    .rx_data_i     (rx_data),
    .fifo_mode_i   (fifo_mode),
    .sdr_mode_i    (sdr),
    .rst_pulse_i   (rst_pulse),
    .start_pulse_i (start_pulse),
    .lane_sel_i    (lane_sel),
    .ptrn_sel_i    (ptrn_sel),
    .bit_cnt_o     (bit_cnt),
    .err_cnt_o     (err_cnt),
    .running_o     (running)
  );

  rx_bert_monitor #(
    .NUM_CHK (NUM_CHK)
  ) u_monitor (
    .clk           (clk),
    .check_i       (check_stb),
    .exp_bit_cnt_i (exp_bit_cnt),
    .exp_err_cnt_i (exp_err_cnt),
    .exp_running_i (exp_running),
    .bit_cnt_i     (bit_cnt),
    .err_cnt_i     (err_cnt),
    .running_i     (running),
    .check_cnt_o   (check_cnt),
    .error_cnt_o   (error_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //------------------------------------------------------------
  // Table setup
  //------------------------------------------------------------
  task automatic set_row(input int r, input rx_bert_pkg::fifo_mode_e mode, input logic sdr_v,
                         input int lane0, input int lane1, input logic ptrn0,
                         input logic ptrn1, input int len);
    row_mode[r]     = mode;
    row_sdr[r]      = sdr_v;
    row_len[r]      = len;
    row_lane[r][0]  = lane0;
    row_lane[r][1]  = lane1;
    row_ptrn[r][0]  = ptrn0;
    row_ptrn[r][1]  = ptrn1;
    row_nflip[r][0] = 0;
    row_nflip[r][1] = 0;
  endtask

  task automatic add_flip(input int r, input int c, input int pos);
    row_flip[r][c][row_nflip[r][c]] = pos;  // Bit index in the lane stream
    row_nflip[r][c]++;
  endtask

  task automatic load_table();
    set_row(0, rx_bert_pkg::FIFO_1X, 1'b1, 0, 3, 1'b0, 1'b1, 60);  // 1 bit clean stream
    set_row(1, rx_bert_pkg::FIFO_1X, 1'b0, 2, 5, 1'b1, 1'b0, 50);  // 2 bits
    set_row(2, rx_bert_pkg::FIFO_2X, 1'b0, 7, 1, 1'b0, 1'b0, 40);  // 4 bits
    set_row(3, rx_bert_pkg::FIFO_4X, 1'b0, 4, 6, 1'b1, 1'b1, 40);  // 8 bits
    set_row(4, rx_bert_pkg::FIFO_4X, 1'b1, 1, 9, 1'b1, 1'b1, 30);  // Lane 9 out of range
    set_row(5, rx_bert_pkg::FIFO_2X, 1'b1, 6, 0, 1'b0, 1'b1, 40);  // 2 bits
    add_flip(1, 0, 20);
    add_flip(1, 0, 55);
    add_flip(1, 0, 90);
    add_flip(1, 1, 16);   // First bit after seeding
    add_flip(2, 0, 100);
    add_flip(2, 1, 30);
    add_flip(2, 1, 31);   // Adjacent flips count twice
    add_flip(3, 0, 16);
    add_flip(3, 0, 200);
    add_flip(3, 0, 319);  // Last counted bit
    add_flip(4, 0, 64);
    add_flip(5, 1, 79);
  endtask

  // Bits per clock from FIFO rate and data rate
  function automatic int nbits_of(input rx_bert_pkg::fifo_mode_e mode, input logic sdr_v);
    int base;
    base = 1 << mode;  // 1, 2 or 4 in single data rate
    return sdr_v ? base : 2 * base;
  endfunction

  //------------------------------------------------------------
  // Stream model
  //------------------------------------------------------------
  task automatic build_streams(input int r, input int total);
    int          taps;
    int          q;
    logic [14:0] init;
    for (int c = 0; c < NUM_CHK; c++)
    begin
      taps = row_ptrn[r][c] ? 15 : 7;
      init = 15'($random(seed));
      init = init & ((15'd1 << taps) - 15'd1);
      if (cur_lane[c] >= NUM_LANES)
        init = '0;          // Zero data seeds a zero register
      else if (init == '0)
        init = 15'd1;       // Avoid the stuck state
      for (int p = 0; p < total; p++)
      begin
        if (p < taps)
          clean_bits[c][p] = init[p];
        else
          clean_bits[c][p] = clean_bits[c][p-taps] ^ clean_bits[c][p-taps+1];
        line_bits[c][p] = (cur_lane[c] < NUM_LANES) ? clean_bits[c][p] : 1'b0;
      end
      for (int f = 0; f < row_nflip[r][c]; f++)
      begin
        q = row_flip[r][c][f];
        line_bits[c][q] = ~line_bits[c][q];
      end
    end
  endtask

  // Mismatches between line and pattern after seeding
  function automatic int expected_errors(input int c, input int n_bits);
    int n;
    n = 0;
    for (int p = rx_bert_pkg::SEED_BITS; p < n_bits; p++)
    begin
      if (line_bits[c][p] != clean_bits[c][p])
        n++;
    end
    return n;
  endfunction

  // Word j of the stream with garbage in unused lanes and slots
  task automatic drive_word(input int j);
    logic [WORD_W-1:0] w;
    for (int b = 0; b < WORD_W; b += 32)
      w[b +: 32] = $random(seed);
    for (int c = 0; c < NUM_CHK; c++)
    begin
      if (cur_lane[c] < NUM_LANES)
      begin
        for (int k = 0; k < cur_nbits; k++)
          w[k*NUM_LANES + cur_lane[c]] = line_bits[c][j*cur_nbits + k];
      end
    end
    rx_data <= w;
  endtask

  task automatic expect_counts(input logic [31:0] bits, input logic [EW*NUM_CHK-1:0] errs,
                               input logic [NUM_CHK-1:0] run);
    check_stb   <= 1'b1;
    exp_bit_cnt <= bits;
    exp_err_cnt <= errs;
    exp_running <= run;
  endtask

  //------------------------------------------------------------
  // One table row with reset pulse, start, stream and check
  //------------------------------------------------------------
  task automatic run_row(input int r);
    logic [6*NUM_CHK-1:0]  sel_v;
    logic [NUM_CHK-1:0]    ptrn_v;
    logic [EW*NUM_CHK-1:0] err_v;
    int                    len;
    int                    j;
    int                    waits;
    len       = row_len[r];
    cur_nbits = nbits_of(row_mode[r], row_sdr[r]);
    for (int c = 0; c < NUM_CHK; c++)
    begin
      cur_lane[c]      = row_lane[r][c];
      sel_v[c*6 +: 6]  = 6'(row_lane[r][c]);
      ptrn_v[c]        = row_ptrn[r][c];
    end
    build_streams(r, (len + 2) * cur_nbits);
    for (int c = 0; c < NUM_CHK; c++)
      err_v[c*EW +: EW] = EW'(expected_errors(c, len * cur_nbits));

    @(posedge clk);
    check_stb <= 1'b0;
    rst_pulse <= '1;        // Stop the previous row
    fifo_mode <= row_mode[r];
    sdr       <= row_sdr[r];
    lane_sel  <= sel_v;
    ptrn_sel  <= ptrn_v;
    @(posedge clk);
    rst_pulse <= '0;
    expect_counts('0, '0, '0);  // Cleared one cycle after the pulse
    @(posedge clk);
    check_stb   <= 1'b0;
    start_pulse <= '1;
    drive_word(0);          // Seeding starts with this word
    @(posedge clk);
    start_pulse <= '0;
    drive_word(1);
    j     = 2;
    waits = 0;
    @(negedge clk);
    while (!(&running) && waits < RUN_TIMEOUT)
    begin
      @(posedge clk);
      drive_word(j);
      j++;
      waits++;
      @(negedge clk);
    end
    if (!(&running))
    begin
      $display("Timeout: checkers not running %0d cycles after start in row %0d", waits, r);
      timeouts++;
    end
    else
    begin
      while (j <= len + 1)
      begin
        @(posedge clk);
        drive_word(j);
        if (j == len + 1)
          expect_counts(cur_nbits * len, err_v, '1);  // Bit count covers len words here
        j++;
      end
    end
  endtask

  initial
  begin
    rstn        = 1'b0;
    rx_data     = '0;
    fifo_mode   = rx_bert_pkg::FIFO_1X;
    sdr         = 1'b1;
    rst_pulse   = '0;
    start_pulse = '0;
    lane_sel    = '0;
    ptrn_sel    = '0;
    check_stb   = 1'b0;
    exp_bit_cnt = '0;
    exp_err_cnt = '0;
    exp_running = '0;
    timeouts    = 0;
    load_table();
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    expect_counts('0, '0, '0);  // Quiet out of reset
    for (int r = 0; r < NUM_ROWS && timeouts == 0; r++)
      run_row(r);
    @(posedge clk);
    check_stb <= 1'b0;
    @(posedge clk);
    if (check_cnt != NUM_CHECKS)
      $display("Monitor saw %0d check strobes where %0d were due", check_cnt, NUM_CHECKS);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, error_cnt, timeouts);
    if (error_cnt == 0 && timeouts == 0 && check_cnt == NUM_CHECKS)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== tb.f ====
source/rx_bert_pkg.sv
source/bert_chk_if.sv
source/rx_lane_select.sv
source/bert_chk_fsm.sv
source/prbs_checker.sv
source/rx_bit_counter.sv
source/rx_bert_top.sv
tb/rx_bert_monitor.sv
tb/tb_rx_bert.sv

// ==== Bender.yml ====
package:
  name: rx_bert

sources:
  - files:
      - source/rx_bert_pkg.sv
      - source/bert_chk_if.sv
      - source/rx_lane_select.sv
      - source/bert_chk_fsm.sv
      - source/prbs_checker.sv
      - source/rx_bit_counter.sv
      - source/rx_bert_top.sv
  - target: test
    files:
      - tb/rx_bert_monitor.sv
      - tb/tb_rx_bert.sv
